// ==== hw/glueTypes.sv ====
`default_nettype none

package glueTypes;

	// what the 68000 drives during one bus cycle
	typedef struct packed {
		logic [23:8] addr; // A23..A8, A7..A1 not needed for decode
		logic asN; // address strobe, asynchronous to CLK
		logic writeN; // R/W line, low on write
	} cpuBusT;

	// device selects, all combinational from the address
	typedef struct packed {
		logic ioSel; // cycle goes out on the I/O bus
		logic ioWriteSnoop; // write into video or sound buffer
		logic iackSel; // interrupt acknowledge space
		logic romSel; // any ROM access
		logic romHighSel; // 0x4xxxxx
		logic ramSel; // RAM, only once overlay is gone
		logic ramLowSel; // low 4 MB
		logic soundWriteSel; // write into the sound buffer
	} chipSelT;

	// which sequencer ends the cycle with DTACK
	typedef enum logic [1:0] {
		routeNone = 2'd0, // nobody answers
		routeMem = 2'd1, // fixed wait states
		routeIo = 2'd2 // waits for the I/O bus acknowledge
	} routeT;

	// wait states for ROM and RAM cycles
	parameter logic [3:0] defaultMemWait = 4'd2;

endpackage

`default_nettype wire

// ==== hw/addrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module addrDecode (
	input wire logic CLK,
	input wire logic rstN,
	input wire glueTypes::cpuBusT cpuBus,
	input wire logic busActive,
	output glueTypes::chipSelT selects,
	output glueTypes::routeT route,
	output logic overlay
);
	import glueTypes::*;

	logic [3:0] topNib;
	logic [7:0] page; // A15..A8 inside the 64 KB block
	logic romHigh;
	logic rom;
	logic ramLow;
	logic ram;
	logic iack;
	logic topRamWrite;
	logic snoop;
	logic sndWrite;
	logic io;
	logic romHighSeen; // this cycle hit the high ROM

	// video pages in 3Fxxxx that must also go out on the I/O bus
	function automatic logic videoPage(input logic [7:0] pg);
		logic [3:0] hi;
		logic [3:0] lo;
		hi = pg[7:4];
		lo = pg[3:0];
		case (hi)
			4'h2: videoPage = lo >= 4'h7;
			4'h3, 4'h4, 4'h5, 4'h6: videoPage = 1'b1;
			4'h7: videoPage = lo <= 4'hC; // A7 not on the bus, whole 3F7C page snooped
			4'hA: videoPage = (lo >= 4'h1 && lo <= 4'h3) || lo >= 4'h7;
			4'hB, 4'hC, 4'hE: videoPage = 1'b1;
			4'hF: videoPage = 1'b1; // 3FFC treated as a full page as well
			default: videoPage = 1'b0;
		endcase
	endfunction

	// the two sound buffers
	function automatic logic soundPage(input logic [7:0] pg);
		logic [3:0] hi;
		logic [3:0] lo;
		hi = pg[7:4];
		lo = pg[3:0];
		soundPage = (hi == 4'hA && lo >= 4'h1 && lo <= 4'h3) ||
			(hi == 4'hF && lo >= 4'hD);
	endfunction

	assign topNib = cpuBus.addr[23:20];
	assign page = cpuBus.addr[15:8];

	always_comb begin
		romHigh = topNib == 4'h4;
		rom = romHigh || (topNib == 4'h0 && overlay); // boot ROM mirrored at 0
		ramLow = cpuBus.addr[23:22] == 2'b00;
		ram = ramLow && !overlay;
		iack = topNib == 4'hF && cpuBus.addr[19:18] == 2'b11;
		topRamWrite = ram && !cpuBus.writeN && cpuBus.addr[23:16] == 8'h3F;
		snoop = topRamWrite && videoPage(page);
		sndWrite = topRamWrite && soundPage(page);
		io = topNib >= 4'h5 || (romHigh && overlay) || snoop;
	end

	always_comb begin
		selects.ioSel = io;
		selects.ioWriteSnoop = snoop;
		selects.iackSel = iack;
		selects.romSel = rom;
		selects.romHighSel = romHigh;
		selects.ramSel = ram;
		selects.ramLowSel = ramLow;
		selects.soundWriteSel = sndWrite;
	end

	// I/O wins, so snooped RAM writes wait for the slow bus
	always_comb begin
		if (io)
			route = routeIo;
		else if (rom || ram)
			route = routeMem;
		else
			route = routeNone; // low region under overlay outside ROM
	end

	// overlay drops once a cycle to the high ROM has finished
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			overlay <= 1'b1;
			romHighSeen <= 1'b0;
		end else if (!busActive) begin
			romHighSeen <= 1'b0;
			if (romHighSeen)
				overlay <= 1'b0; // never set again until reset
		end else if (romHigh) begin
			romHighSeen <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/busCycleControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module busCycleControl (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic asN,
	input wire logic memDone,
	input wire logic ioDone,
	output logic busActive,
	output logic cycleStart,
	output logic dtackN
);

	logic [1:0] asSync; // two-flop synchronizer for the strobe
	logic busActiveQ;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			asSync <= 2'b11;
			busActiveQ <= 1'b0;
		end else begin
			asSync <= {asSync[0], asN};
			busActiveQ <= busActive;
		end
	end

	assign busActive = !asSync[1];
	assign cycleStart = busActive && !busActiveQ; // first clock of the cycle

	// one DTACK for both sequencers
	// asSync[0] high means busActive goes low at this edge
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			dtackN <= 1'b1;
		else if (asSync[0])
			dtackN <= 1'b1; // release with the end of the cycle
		else if (busActive && (memDone || ioDone))
			dtackN <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== hw/memCycle.sv ====
`timescale 1ns/1ps
`default_nettype none

module memCycle #(
	parameter logic [3:0] memWaitStates = glueTypes::defaultMemWait
) (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic cycleStart,
	input wire logic busActive,
	input wire glueTypes::routeT route,
	output logic memDone
);
	import glueTypes::*;

	logic [3:0] waitCnt; // clocks left before memDone

	// memDone comes memWaitStates clocks after the start pulse
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			waitCnt <= 4'd0;
			memDone <= 1'b0;
		end else if (!busActive) begin
			waitCnt <= 4'd0;
			memDone <= 1'b0;
		end else if (cycleStart && route == routeMem) begin
			if (memWaitStates <= 4'd1)
				memDone <= 1'b1; // no extra wait
			else
				waitCnt <= memWaitStates - 4'd1;
		end else if (waitCnt != 4'd0) begin
			waitCnt <= waitCnt - 4'd1;
			if (waitCnt == 4'd1)
				memDone <= 1'b1; // held until the cycle ends
		end
	end

endmodule

`default_nettype wire

// ==== hw/ioCycle.sv ====
`timescale 1ns/1ps
`default_nettype none

module ioCycle (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic cycleStart,
	input wire logic busActive,
	input wire glueTypes::routeT route,
	input wire logic ioAck,
	output logic ioReq,
	output logic ioDone
);
	import glueTypes::*;

	typedef enum logic [1:0] {
		stIdle = 2'd0,
		stRequest = 2'd1, // request out, waiting for ack
		stDone = 2'd2 // acked, DTACK may go
	} ioStateT;

	ioStateT state;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
		end else if (!busActive) begin
			state <= stIdle; // strobe gone, drop everything
		end else begin
			case (state)
				stIdle:
					if (cycleStart && route == routeIo)
						state <= stRequest;
				stRequest:
					if (ioAck)
						state <= stDone;
				stDone:
					state <= stDone; // wait for the strobe to go
				default:
					state <= stIdle;
			endcase
		end
	end

	// both levels straight from the state register
	assign ioReq = state == stRequest;
	assign ioDone = state == stDone;

endmodule

`default_nettype wire

// ==== hw/glueTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module glueTop #(
	parameter logic [3:0] memWaitStates = glueTypes::defaultMemWait
) (
	input wire logic CLK,
	input wire logic rstN,
	input wire glueTypes::cpuBusT cpuBus,
	input wire logic ioAck,
	output glueTypes::chipSelT selects,
	output logic ioReq,
	output logic dtackN,
	output logic overlay
);
	import glueTypes::*;

	logic busActive;
	logic cycleStart;
	logic memDone;
	logic ioDone;
	routeT route; // decided once, read by both sequencers

	busCycleControl busCtl (
		.CLK(CLK),
		.rstN(rstN),
		.asN(cpuBus.asN),
		.memDone(memDone),
		.ioDone(ioDone),
		.busActive(busActive),
		.cycleStart(cycleStart),
		.dtackN(dtackN)
	);

	addrDecode decode (
		.CLK(CLK),
		.rstN(rstN),
		.cpuBus(cpuBus),
		.busActive(busActive),
		.selects(selects),
		.route(route),
		.overlay(overlay)
	);

	memCycle #(
		.memWaitStates(memWaitStates)
	) memSeq (
		.CLK(CLK),
		.rstN(rstN),
		.cycleStart(cycleStart),
		.busActive(busActive),
		.route(route),
		.memDone(memDone)
	);

	ioCycle ioSeq (
		.CLK(CLK),
		.rstN(rstN),
		.cycleStart(cycleStart),
		.busActive(busActive),
		.route(route),
		.ioAck(ioAck),
		.ioReq(ioReq),
		.ioDone(ioDone)
	);

endmodule

`default_nettype wire

// ==== testbench/glueAssertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module glueAssertions #(
	parameter logic [3:0] memWaitStates = glueTypes::defaultMemWait
) (
	input wire logic CLK,
	input wire logic rstN,
	input wire glueTypes::chipSelT selects,
	input wire glueTypes::routeT route,
	input wire logic overlay,
	input wire logic busActive,
	input wire logic cycleStart,
	input wire logic ioAck,
	input wire logic ioReq,
	input wire logic dtackN
);
	import glueTypes::*;

	localparam int memLatency = memWaitStates + 1; // cycleStart to dtackN low
	int failCount = 0; // failed assertions so far

	overlayClearsAfterRomHigh: assert property (@(posedge CLK) disable iff (!rstN)
		(busActive && selects.romHighSel) ##1 !busActive |=> !overlay)
		else begin $error("overlay still set after a high ROM cycle ended"); failCount++; end

	soundInsideWindow: assert property (@(posedge CLK) disable iff (!rstN)
		selects.soundWriteSel |-> selects.ioWriteSnoop)
		else begin $error("sound write outside the video/sound window"); failCount++; end

	reqAfterStart: assert property (@(posedge CLK) disable iff (!rstN)
		cycleStart && route == routeIo |=> ioReq)
		else begin $error("ioReq did not rise after an I/O cycle start"); failCount++; end

	reqHeldUntilAck: assert property (@(posedge CLK) disable iff (!rstN)
		ioReq && !ioAck && busActive |=> ioReq)
		else begin $error("ioReq dropped before ioAck"); failCount++; end

	dtackAfterAck: assert property (@(posedge CLK) disable iff (!rstN)
		ioReq && ioAck && busActive |=> ##1 !dtackN)
		else begin $error("dtackN did not fall after the I/O acknowledge"); failCount++; end

	memDtackLatency: assert property (@(posedge CLK) disable iff (!rstN)
		cycleStart && route == routeMem |-> dtackN [*memLatency] ##1 !dtackN)
		else begin $error("memory cycle DTACK came at the wrong clock"); failCount++; end

	reqDropsWithBus: assert property (@(posedge CLK) disable iff (!rstN)
		!busActive |=> !ioReq)
		else begin $error("ioReq stayed high after the bus cycle ended"); failCount++; end

	dtackIdleHigh: assert property (@(posedge CLK) disable iff (!rstN)
		!busActive |-> dtackN)
		else begin $error("dtackN low while no bus cycle is active"); failCount++; end

	noDtackWithoutRoute: assert property (@(posedge CLK) disable iff (!rstN)
		busActive && route == routeNone |-> dtackN)
		else begin $error("DTACK given to a cycle that nobody answers"); failCount++; end

endmodule

bind glueTop glueAssertions #(.memWaitStates(memWaitStates)) checks (.*);

`default_nettype wire

// ==== testbench/glueTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module glueTb;
	import glueTypes::*;

	localparam logic [3:0] waitStates = 4'd2;
	localparam int memLatency = 2 + waitStates + 1; // asN low to dtackN low
	localparam int waitLimit = 200; // clocks before a wait gives up

	logic CLK;
	logic rstN;
	cpuBusT cpuBus;
	logic ioAck;
	chipSelT selects;
	logic ioReq;
	logic dtackN;
	logic overlay;

	logic [31:0] lfsr;
	logic expOverlay; // model of the boot overlay
	int errorCount;
	logic [23:8] addr;
	logic wr;
	int i;

	glueTop #(.memWaitStates(waitStates)) UUT (
		.CLK(CLK),
		.rstN(rstN),
		.cpuBus(cpuBus),
		.ioAck(ioAck),
		.selects(selects),
		.ioReq(ioReq),
		.dtackN(dtackN),
		.overlay(overlay)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// Galois LFSR, one step for each bit taken
	function automatic logic [15:0] randomBits(input int n);
		logic [15:0] r;
		int k;
		r = '0;
		for (k = 0; k < n; k++) begin
			r = {r[14:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		end
		return r;
	endfunction

	// pages of 3Fxxxx, the 3F7C and 3FFC half pages count whole since A7 is not seen
	function automatic logic videoWindow(input logic [7:0] pg);
		return (pg >= 8'h27 && pg <= 8'h7C) || (pg >= 8'hA1 && pg <= 8'hA3) ||
			(pg >= 8'hA7 && pg <= 8'hCF) || pg >= 8'hE0;
	endfunction

	function automatic logic soundBuffer(input logic [7:0] pg);
		return (pg >= 8'hA1 && pg <= 8'hA3) || pg >= 8'hFD;
	endfunction

	function automatic chipSelT modelDecode(input logic [23:8] a, input logic w, input logic ov);
		chipSelT s;
		logic [3:0] nib;
		logic topBlock;
		nib = a[23:20];
		topBlock = w && a[23:16] == 8'h3F; // write into the top 64 KB of RAM
		s.romHighSel = nib == 4'h4;
		s.romSel = s.romHighSel || (nib == 4'h0 && ov);
		s.ramLowSel = a[23:22] == 2'b00;
		s.ramSel = s.ramLowSel && !ov;
		s.iackSel = nib == 4'hF && a[19:18] == 2'b11;
		s.ioWriteSnoop = topBlock && s.ramSel && videoWindow(a[15:8]);
		s.soundWriteSel = topBlock && s.ramSel && soundBuffer(a[15:8]);
		s.ioSel = nib >= 4'h5 || (s.romHighSel && ov) || s.ioWriteSnoop;
		return s;
	endfunction

	function automatic routeT modelRoute(input chipSelT s);
		if (s.ioSel)
			return routeIo;
		else if (s.romSel || s.ramSel)
			return routeMem;
		return routeNone;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			errorCount++;
		end
	endtask

	// plays the I/O bus side, acks after a random delay
	task automatic answerIo(input int delay);
		int count;
		count = 0;
		while (!ioReq && count < waitLimit) begin
			@(negedge CLK);
			count++;
		end
		if (!ioReq) begin
			$display("ioReq never rose on an I/O cycle");
			errorCount++;
		end else begin
			repeat (delay) @(negedge CLK);
			ioAck = 1'b1;
			count = 0;
			while (ioReq && count < waitLimit) begin
				@(negedge CLK);
				count++;
			end
			if (ioReq) begin
				$display("ioReq stayed high after ioAck");
				errorCount++;
			end
			ioAck = 1'b0;
		end
	endtask

	task automatic runCycle(input logic [23:8] a, input logic w);
		chipSelT expSel;
		routeT expRoute;
		int count;
		int ackDelay;
		expSel = modelDecode(a, w, expOverlay);
		expRoute = modelRoute(expSel);
		ackDelay = randomBits(3);
		@(negedge CLK);
		cpuBus.addr = a;
		cpuBus.writeN = !w;
		cpuBus.asN = 1'b0;
		@(negedge CLK);
		compareValue("selects", selects, expSel);
		compareValue("route", UUT.route, expRoute);
		compareValue("overlay", overlay, expOverlay);
		count = 1;
		if (expRoute == routeNone) begin
			repeat (12) @(negedge CLK); // nobody answers
			compareValue("dtackN", dtackN, 1'b1);
		end else begin
			if (expRoute == routeIo)
				answerIo(ackDelay);
			while (dtackN && count < waitLimit) begin
				@(negedge CLK);
				count++;
			end
			if (dtackN) begin
				$display("dtackN never fell for address %h", a);
				errorCount++;
			end else if (expRoute == routeMem) begin
				compareValue("dtackN latency", count, memLatency);
			end
		end
		cpuBus.asN = 1'b1;
		count = 0;
		while (!dtackN && count < 3) begin
			@(negedge CLK);
			count++;
		end
		if (!dtackN) begin
			$display("dtackN not released within 3 clocks of asN rising");
			errorCount++;
		end
		repeat (4) @(negedge CLK); // let busActive and the overlay settle
		if (expSel.romHighSel)
			expOverlay = 1'b0;
	endtask

	initial begin
		lfsr = 32'hf645;
		errorCount = 0;
		expOverlay = 1'b1;
		rstN = 1'b0;
		ioAck = 1'b0;
		cpuBus.addr = 16'h0000;
		cpuBus.asN = 1'b1;
		cpuBus.writeN = 1'b1;
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		rstN = 1'b1;
		compareValue("ioReq", ioReq, 1'b0);
		compareValue("dtackN", dtackN, 1'b1);
		compareValue("overlay", overlay, 1'b1);

		runCycle(16'h0000 | randomBits(12), 1'b0); // boot ROM mirror
		runCycle(16'h2000 | randomBits(12), 1'b0); // hidden RAM, no answer
		runCycle(16'h4000 | randomBits(12), 1'b0); // first high ROM fetch
		compareValue("overlay", overlay, 1'b0);
		runCycle(16'h0000 | randomBits(12), 1'b1);
		runCycle(16'h4000 | randomBits(12), 1'b0);

		for (i = 0; i < 40; i++) begin
			addr = randomBits(16);
			if (i % 8 == 7)
				addr[23:18] = 6'b111111; // interrupt acknowledge space
			wr = randomBits(1) != 16'd0;
			runCycle(addr, wr);
		end

		runCycle(16'h3FA2, 1'b1); // sound buffers
		runCycle(16'h3FFE, 1'b1);
		for (i = 0; i < 40; i++) begin
			addr = 16'h3F00 | randomBits(8);
			wr = randomBits(1) != 16'd0;
			runCycle(addr, wr);
		end

		repeat (4) @(negedge CLK);
		$display("Closing: %0d check errors, %0d assertion failures", errorCount,
			UUT.checks.failCount);
		if (errorCount == 0 && UUT.checks.failCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== glueDecode.f ====
hw/glueTypes.sv
hw/addrDecode.sv
hw/busCycleControl.sv
hw/memCycle.sv
hw/ioCycle.sv
hw/glueTop.sv
testbench/glueAssertions.sv
testbench/glueTb.sv
